/* Bender.yml */
package:
  name: exec_unit

sources:
  - files:
      - design/exec_pkg.sv
      - design/inst_decode.sv
      - design/operand_select.sv
      - design/alu.sv
      - design/branch_unit.sv
      - design/exec_commit.sv
      - design/exec_unit.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_exec_unit.sv

/* design/alu.sv */
`timescale 1ns/1ps

module alu (
    input  exec_pkg::alu_op_e alu_op,
    input  exec_pkg::xlen_t   op_a,
    input  exec_pkg::xlen_t   op_b,
    output exec_pkg::xlen_t   alu_res
);

    logic [4:0] shamt;

    assign shamt = op_b[4:0];

    always_comb begin
        case (alu_op)
            exec_pkg::alu_add:    alu_res = op_a + op_b;
            exec_pkg::alu_sub:    alu_res = op_a - op_b;
            exec_pkg::alu_sll:    alu_res = op_a << shamt;
            exec_pkg::alu_slt:    alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            exec_pkg::alu_sltu:   alu_res = {31'b0, op_a < op_b};
            exec_pkg::alu_xor:    alu_res = op_a ^ op_b;
            exec_pkg::alu_srl:    alu_res = op_a >> shamt;
            exec_pkg::alu_sra:    alu_res = $signed(op_a) >>> shamt;
            exec_pkg::alu_or:     alu_res = op_a | op_b;
            exec_pkg::alu_and:    alu_res = op_a & op_b;
            // lui passes the immediate
            exec_pkg::alu_pass_b: alu_res = op_b;
            default:              alu_res = '0;
        endcase
    end

endmodule

/* design/branch_unit.sv */
`timescale 1ns/1ps

module branch_unit (
    input  exec_pkg::exec_issue_t issue,
    input  exec_pkg::ctrl_t       ctrl,
    input  exec_pkg::xlen_t       rs1_fwd,
    input  exec_pkg::xlen_t       rs2_fwd,
    output logic                  br_taken,
    output exec_pkg::xlen_t       br_target
);

    logic            eq;
    logic            lt_s;
    logic            lt_u;
    logic            cond;
    exec_pkg::xlen_t jalr_sum;

    // comparator on forwarded operands
    assign eq   = (rs1_fwd == rs2_fwd);
    assign lt_s = ($signed(rs1_fwd) < $signed(rs2_fwd));
    assign lt_u = (rs1_fwd < rs2_fwd);

    always_comb begin
        case (ctrl.br_funct)
            exec_pkg::f3_beq:  cond = eq;
            exec_pkg::f3_bne:  cond = !eq;
            exec_pkg::f3_blt:  cond = lt_s;
            exec_pkg::f3_bge:  cond = !lt_s;
            exec_pkg::f3_bltu: cond = lt_u;
            exec_pkg::f3_bgeu: cond = !lt_u;
            // 010 and 011 are reserved encodings
            default:           cond = 1'b0;
        endcase
    end

    // jumps always leave the sequential path
    assign br_taken = ctrl.is_jal || ctrl.is_jalr || (ctrl.is_branch && cond);

    assign jalr_sum = rs1_fwd + ctrl.imm;

    always_comb begin
        if (ctrl.is_jalr) begin
            br_target = {jalr_sum[31:1], 1'b0};
        end else begin
            br_target = issue.pc + ctrl.imm;
        end
    end

endmodule

/* design/exec_commit.sv */
`timescale 1ns/1ps

module exec_commit (
    input  logic                   clk,
    input  logic                   rst,
    input  exec_pkg::exec_issue_t  issue,
    input  exec_pkg::ctrl_t        ctrl,
    input  exec_pkg::xlen_t        alu_res,
    input  exec_pkg::xlen_t        br_target,
    input  logic                   br_taken,
    output exec_pkg::exec_result_t result,
    output exec_pkg::redirect_t    redirect
);

    logic            take;
    logic            is_jump;
    exec_pkg::xlen_t link_addr;

    // slot right behind a redirect is on the wrong path
    assign take      = issue.valid && !redirect.valid;
    assign is_jump   = ctrl.is_jal || ctrl.is_jalr;
    assign link_addr = issue.pc + 32'd4;

    always_ff @(posedge clk) begin
        result.rd       <= ctrl.rd;
        result.wdata    <= is_jump ? link_addr : alu_res;
        redirect.target <= br_target;
        if (rst) begin
            result.valid   <= 1'b0;
            result.we      <= 1'b0;
            redirect.valid <= 1'b0;
        end else begin
            result.valid   <= take;
            result.we      <= take && ctrl.reg_we;
            redirect.valid <= take && br_taken;
        end
    end

    // rd zero filtering happens back in decode
    a_we_needs_rd: assert property (@(posedge clk) disable iff (rst)
        result.we |-> (result.valid && (result.rd != '0)))
        else $error("exec_commit: write enable with rd 0 or invalid slot");

    // pc word alignment from the issuer plus even immediates
    a_target_even: assert property (@(posedge clk) disable iff (rst)
        redirect.valid |-> (redirect.target[0] == 1'b0))
        else $error("exec_commit: odd redirect target %h", redirect.target);

endmodule

/* design/exec_pkg.sv */
package exec_pkg;

    typedef logic [31:0] xlen_t;
    typedef logic [4:0]  reg_idx_t;

    // major opcodes of the supported RV32I subset
    localparam logic [6:0] opc_op     = 7'b0110011;
    localparam logic [6:0] opc_op_imm = 7'b0010011;
    localparam logic [6:0] opc_lui    = 7'b0110111;
    localparam logic [6:0] opc_auipc  = 7'b0010111;
    localparam logic [6:0] opc_jal    = 7'b1101111;
    localparam logic [6:0] opc_jalr   = 7'b1100111;
    localparam logic [6:0] opc_branch = 7'b1100011;

    // branch conditions
    localparam logic [2:0] f3_beq  = 3'b000;
    localparam logic [2:0] f3_bne  = 3'b001;
    localparam logic [2:0] f3_blt  = 3'b100;
    localparam logic [2:0] f3_bge  = 3'b101;
    localparam logic [2:0] f3_bltu = 3'b110;
    localparam logic [2:0] f3_bgeu = 3'b111;

    // integer op funct3 codes
    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_sll     = 3'b001;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_sltu    = 3'b011;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_srl_sra = 3'b101;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;

    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_sll    = 4'd2,
        alu_slt    = 4'd3,
        alu_sltu   = 4'd4,
        alu_xor    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_or     = 4'd8,
        alu_and    = 4'd9,
        alu_pass_b = 4'd10
    } alu_op_e;

    typedef struct packed {
        logic  valid;
        xlen_t pc;
        xlen_t inst;
        xlen_t rs1_val;
        xlen_t rs2_val;
    } exec_issue_t;

    typedef struct packed {
        alu_op_e    alu_op;
        logic       a_is_pc;
        logic       b_is_imm;
        logic       is_branch;
        logic       is_jal;
        logic       is_jalr;
        logic [2:0] br_funct;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        logic       reg_we;
        xlen_t      imm;
    } ctrl_t;

    typedef struct packed {
        logic     valid;
        logic     we;
        reg_idx_t rd;
        xlen_t    wdata;
    } exec_result_t;

    typedef struct packed {
        logic  valid;
        xlen_t target;
    } redirect_t;

endpackage

/* design/exec_unit.sv */
`timescale 1ns/1ps

module exec_unit (
    input  logic                   clk,
    input  logic                   rst,
    input  exec_pkg::exec_issue_t  issue,
    output exec_pkg::exec_result_t result,
    output exec_pkg::redirect_t    redirect
);

    exec_pkg::ctrl_t ctrl;
    exec_pkg::xlen_t rs1_fwd;
    exec_pkg::xlen_t rs2_fwd;
    exec_pkg::xlen_t op_a;
    exec_pkg::xlen_t op_b;
    exec_pkg::xlen_t alu_res;
    exec_pkg::xlen_t br_target;
    logic            br_taken;

    inst_decode u_decode (
        .issue (issue),
        .ctrl  (ctrl)
    );

    // registered result doubles as the forwarding source
    operand_select u_opsel (
        .issue    (issue),
        .ctrl     (ctrl),
        .result_q (result),
        .rs1_fwd  (rs1_fwd),
        .rs2_fwd  (rs2_fwd),
        .op_a     (op_a),
        .op_b     (op_b)
    );

    alu u_alu (
        .alu_op  (ctrl.alu_op),
        .op_a    (op_a),
        .op_b    (op_b),
        .alu_res (alu_res)
    );

    branch_unit u_branch (
        .issue     (issue),
        .ctrl      (ctrl),
        .rs1_fwd   (rs1_fwd),
        .rs2_fwd   (rs2_fwd),
        .br_taken  (br_taken),
        .br_target (br_target)
    );

    exec_commit u_commit (
        .clk       (clk),
        .rst       (rst),
        .issue     (issue),
        .ctrl      (ctrl),
        .alu_res   (alu_res),
        .br_target (br_target),
        .br_taken  (br_taken),
        .result    (result),
        .redirect  (redirect)
    );

endmodule

/* design/inst_decode.sv */
`timescale 1ns/1ps

module inst_decode (
    input  exec_pkg::exec_issue_t issue,
    output exec_pkg::ctrl_t       ctrl
);

    logic [6:0]      opcode;
    logic [2:0]      funct3;
    logic            alt;
    exec_pkg::xlen_t imm_i;
    exec_pkg::xlen_t imm_u;
    exec_pkg::xlen_t imm_b;
    exec_pkg::xlen_t imm_j;

    assign opcode = issue.inst[6:0];
    assign funct3 = issue.inst[14:12];
    // funct7 bit 30 picks sub and sra
    assign alt    = issue.inst[30];

    assign imm_i = {{20{issue.inst[31]}}, issue.inst[31:20]};
    assign imm_u = {issue.inst[31:12], 12'b0};
    assign imm_b = {{19{issue.inst[31]}}, issue.inst[31], issue.inst[7],
                    issue.inst[30:25], issue.inst[11:8], 1'b0};
    assign imm_j = {{11{issue.inst[31]}}, issue.inst[31], issue.inst[19:12],
                    issue.inst[20], issue.inst[30:21], 1'b0};

    // sub only exists in the register form
    function automatic exec_pkg::alu_op_e int_op(input logic [2:0] f3,
                                                 input logic       f7_alt,
                                                 input logic       from_imm);
        case (f3)
            exec_pkg::f3_add_sub: return (f7_alt && !from_imm) ? exec_pkg::alu_sub
                                                               : exec_pkg::alu_add;
            exec_pkg::f3_sll:     return exec_pkg::alu_sll;
            exec_pkg::f3_slt:     return exec_pkg::alu_slt;
            exec_pkg::f3_sltu:    return exec_pkg::alu_sltu;
            exec_pkg::f3_xor:     return exec_pkg::alu_xor;
            exec_pkg::f3_srl_sra: return f7_alt ? exec_pkg::alu_sra : exec_pkg::alu_srl;
            exec_pkg::f3_or:      return exec_pkg::alu_or;
            default:              return exec_pkg::alu_and;
        endcase
    endfunction

    always_comb begin
        ctrl          = '0;
        ctrl.alu_op   = exec_pkg::alu_add;
        ctrl.br_funct = funct3;
        ctrl.rd       = issue.inst[11:7];
        ctrl.rs1      = issue.inst[19:15];
        ctrl.rs2      = issue.inst[24:20];
        case (opcode)
            exec_pkg::opc_op: begin
                ctrl.alu_op = int_op(funct3, alt, 1'b0);
                ctrl.reg_we = 1'b1;
            end
            exec_pkg::opc_op_imm: begin
                ctrl.alu_op   = int_op(funct3, alt, 1'b1);
                ctrl.b_is_imm = 1'b1;
                ctrl.imm      = imm_i;
                ctrl.reg_we   = 1'b1;
            end
            exec_pkg::opc_lui: begin
                ctrl.alu_op   = exec_pkg::alu_pass_b;
                ctrl.b_is_imm = 1'b1;
                ctrl.imm      = imm_u;
                ctrl.reg_we   = 1'b1;
            end
            exec_pkg::opc_auipc: begin
                ctrl.a_is_pc  = 1'b1;
                ctrl.b_is_imm = 1'b1;
                ctrl.imm      = imm_u;
                ctrl.reg_we   = 1'b1;
            end
            exec_pkg::opc_jal: begin
                ctrl.is_jal = 1'b1;
                ctrl.imm    = imm_j;
                ctrl.reg_we = 1'b1;
            end
            exec_pkg::opc_jalr: begin
                ctrl.is_jalr = 1'b1;
                ctrl.imm     = imm_i;
                ctrl.reg_we  = 1'b1;
            end
            exec_pkg::opc_branch: begin
                ctrl.is_branch = 1'b1;
                ctrl.imm       = imm_b;
            end
            // anything else is a bubble
            default: ctrl.reg_we = 1'b0;
        endcase
        // x0 is never written
        if (ctrl.rd == '0) begin
            ctrl.reg_we = 1'b0;
        end
    end

endmodule

/* design/operand_select.sv */
`timescale 1ns/1ps

module operand_select (
    input  exec_pkg::exec_issue_t  issue,
    input  exec_pkg::ctrl_t        ctrl,
    input  exec_pkg::exec_result_t result_q,
    output exec_pkg::xlen_t        rs1_fwd,
    output exec_pkg::xlen_t        rs2_fwd,
    output exec_pkg::xlen_t        op_a,
    output exec_pkg::xlen_t        op_b
);

    logic fwd_rs1;
    logic fwd_rs2;

    // previous result bypasses the register file value
    assign fwd_rs1 = result_q.valid && result_q.we
                     && (result_q.rd == ctrl.rs1) && (ctrl.rs1 != '0);
    assign fwd_rs2 = result_q.valid && result_q.we
                     && (result_q.rd == ctrl.rs2) && (ctrl.rs2 != '0);

    assign rs1_fwd = fwd_rs1 ? result_q.wdata : issue.rs1_val;
    assign rs2_fwd = fwd_rs2 ? result_q.wdata : issue.rs2_val;

    // auipc takes pc as A
    always_comb begin
        if (ctrl.a_is_pc) begin
            op_a = issue.pc;
        end else begin
            op_a = rs1_fwd;
        end
    end

    always_comb begin
        if (ctrl.b_is_imm) begin
            op_b = ctrl.imm;
        end else begin
            op_b = rs2_fwd;
        end
    end

endmodule

/* tb.f */
+incdir+testbench
design/exec_pkg.sv
design/inst_decode.sv
design/operand_select.sv
design/alu.sv
design/branch_unit.sv
design/exec_commit.sv
design/exec_unit.sv
testbench/tb_exec_unit.sv

/* testbench/exec_ref_model.svh */
// immediates taken straight from the ISA encodings
function automatic logic [31:0] decode_imm(input logic [31:0] in);
    case (in[6:0])
        exec_pkg::opc_lui, exec_pkg::opc_auipc: return {in[31:12], 12'h000};
        exec_pkg::opc_jal: return 32'($signed({in[31], in[19:12], in[20], in[30:21], 1'b0}));
        exec_pkg::opc_branch: return 32'($signed({in[31], in[7], in[30:25], in[11:8], 1'b0}));
        default: return 32'($signed(in[31:20]));
    endcase
endfunction

function automatic logic [31:0] int_result(input logic [2:0] f3, input logic alt,
                                           input logic [31:0] a, input logic [31:0] b);
    case (f3)
        3'd0: return alt ? a - b : a + b;
        3'd1: return a << b[4:0];
        3'd2: return {31'd0, $signed(a) < $signed(b)};
        3'd3: return {31'd0, a < b};
        3'd4: return a ^ b;
        3'd5: begin
            if (alt) return $signed(a) >>> b[4:0];
            return a >> b[4:0];
        end
        3'd6: return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic cond_taken(input logic [2:0] f3, input logic [31:0] a,
                                    input logic [31:0] b);
    case (f3)
        3'd0: return a == b;
        3'd1: return a != b;
        3'd4: return $signed(a) < $signed(b);
        3'd5: return $signed(a) >= $signed(b);
        3'd6: return a < b;
        3'd7: return a >= b;
        default: return 1'b0;
    endcase
endfunction

// res and rdr hold the last result and redirect, updated in place
task automatic model_step(input exec_pkg::exec_issue_t iss,
                          inout exec_pkg::exec_result_t res,
                          inout exec_pkg::redirect_t rdr);
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [31:0] imm;
    logic [31:0] a;
    logic [31:0] b;
    logic        keep;
    rd  = iss.inst[11:7];
    rs1 = iss.inst[19:15];
    rs2 = iss.inst[24:20];
    f3  = iss.inst[14:12];
    imm = decode_imm(iss.inst);
    // bypass from the last kept result but never from x0
    a = (res.valid && res.we && rs1 != 0 && res.rd == rs1) ? res.wdata : iss.rs1_val;
    b = (res.valid && res.we && rs2 != 0 && res.rd == rs2) ? res.wdata : iss.rs2_val;
    // slot right after a redirect is dropped
    keep = iss.valid && !rdr.valid;
    res = '0;
    rdr = '0;
    res.valid = keep;
    res.rd = rd;
    case (iss.inst[6:0])
        exec_pkg::opc_op: begin
            res.we = 1'b1;
            res.wdata = int_result(f3, iss.inst[30], a, b);
        end
        exec_pkg::opc_op_imm: begin
            res.we = 1'b1;
            res.wdata = int_result(f3, iss.inst[30] && f3 == 3'd5, a, imm);
        end
        exec_pkg::opc_lui: begin
            res.we = 1'b1;
            res.wdata = imm;
        end
        exec_pkg::opc_auipc: begin
            res.we = 1'b1;
            res.wdata = iss.pc + imm;
        end
        exec_pkg::opc_jal, exec_pkg::opc_jalr: begin
            res.we = 1'b1;
            res.wdata = iss.pc + 32'd4;
            rdr.valid = 1'b1;
            if (iss.inst[6:0] == exec_pkg::opc_jalr) rdr.target = (a + imm) & ~32'd1;
            else rdr.target = iss.pc + imm;
        end
        exec_pkg::opc_branch: begin
            rdr.valid = cond_taken(f3, a, b);
            rdr.target = iss.pc + imm;
        end
        default: ;
    endcase
    res.we = res.we && keep && rd != 0;
    rdr.valid = rdr.valid && keep;
endtask

/* testbench/tb_exec_unit.sv */
`timescale 1ns/1ps

module tb_exec_unit;

    localparam int num_issues = 2000;
    localparam int max_cycles = num_issues + 20;

    logic                   clk = 1'b0;
    logic                   rst;
    exec_pkg::exec_issue_t  issue;
    exec_pkg::exec_result_t result;
    exec_pkg::redirect_t    redirect;

    exec_pkg::exec_result_t exp_res;
    exec_pkg::redirect_t    exp_rdr;
    logic [31:0]            rng_state;
    logic [4:0]             prev_rd;
    int                     cycle_count = 0;

    `include "exec_ref_model.svh"

    exec_unit dut0 (
        .clk      (clk),
        .rst      (rst),
        .issue    (issue),
        .result   (result),
        .redirect (redirect)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= max_cycles) begin
            $display("timeout: run went past %0d cycles", max_cycles);
            $display("=== FAIL ===");
            $fatal(1, "timeout");
        end
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] rand32();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // random issue with sources often pointing at the last rd
    function automatic exec_pkg::exec_issue_t make_issue(input logic [4:0] dep_rd);
        exec_pkg::exec_issue_t iss;
        logic [31:0] in;
        logic [31:0] r;
        logic [31:0] sel;
        logic [31:0] p;
        in  = rand32();
        r   = rand32();
        sel = r % 32'd100;
        if (sel < 10) begin
            // load, store, system, fence are all bubbles here
            case (r[9:8])
                2'd0: in[6:0] = 7'b0000011;
                2'd1: in[6:0] = 7'b0100011;
                2'd2: in[6:0] = 7'b1110011;
                default: in[6:0] = 7'b0001111;
            endcase
        end
        else if (sel < 32) in[6:0] = exec_pkg::opc_op;
        else if (sel < 50) in[6:0] = exec_pkg::opc_op_imm;
        else if (sel < 57) in[6:0] = exec_pkg::opc_lui;
        else if (sel < 64) in[6:0] = exec_pkg::opc_auipc;
        else if (sel < 71) in[6:0] = exec_pkg::opc_jal;
        else if (sel < 78) in[6:0] = exec_pkg::opc_jalr;
        else in[6:0] = exec_pkg::opc_branch;
        // legal funct7 has bit 30 only on add/sub and shifts
        if (in[6:0] == exec_pkg::opc_op)
            in[31:25] = {1'b0, r[10] && (in[14:12] == 3'd0 || in[14:12] == 3'd5), 5'd0};
        if (in[6:0] == exec_pkg::opc_op_imm && in[13:12] == 2'b01)
            in[31:25] = {1'b0, r[10] && in[14], 5'd0};
        if (in[6:0] == exec_pkg::opc_jalr) in[14:12] = 3'd0;
        if (in[6:0] == exec_pkg::opc_branch && in[14:13] == 2'b01) in[14] = 1'b1;
        if (r[11]) in[19:15] = dep_rd;
        if (r[12]) in[24:20] = dep_rd;
        p = rand32();
        iss.valid   = (rand32() % 32'd100) >= 15;
        iss.pc      = {p[31:2], 2'b00};
        iss.inst    = in;
        iss.rs1_val = rand32();
        // equal operands now and then for beq and bge
        iss.rs2_val = r[13] ? iss.rs1_val : rand32();
        return iss;
    endfunction

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %s got 0x%08h expected 0x%08h", name, got, exp);
            $display("=== FAIL ===");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic compare_outputs(input exec_pkg::exec_result_t er,
                                   input exec_pkg::redirect_t ed);
        check_val("result.valid", result.valid, er.valid);
        check_val("result.we", result.we, er.we);
        check_val("redirect.valid", redirect.valid, ed.valid);
        if (er.valid) check_val("result.rd", result.rd, er.rd);
        if (er.we) check_val("result.wdata", result.wdata, er.wdata);
        if (ed.valid) check_val("redirect.target", redirect.target, ed.target);
    endtask

    initial begin
        exec_pkg::exec_issue_t  nxt;
        exec_pkg::exec_result_t chk_res;
        exec_pkg::redirect_t    chk_rdr;
        rst       = 1'b1;
        issue     = '0;
        rng_state = 32'h49dc0354;
        prev_rd   = 5'd1;
        exp_res   = '0;
        exp_rdr   = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        // outputs idle straight out of reset
        @(negedge clk);
        compare_outputs('0, '0);
        for (int i = 0; i < num_issues; i++) begin
            @(posedge clk);
            nxt = make_issue(prev_rd);
            issue <= nxt;
            chk_res = exp_res;
            chk_rdr = exp_rdr;
            model_step(nxt, exp_res, exp_rdr);
            if (nxt.valid) prev_rd = nxt.inst[11:7];
            @(negedge clk);
            compare_outputs(chk_res, chk_rdr);
        end
        @(posedge clk);
        issue <= '0;
        @(negedge clk);
        compare_outputs(exp_res, exp_rdr);
        $display("=== PASS ===");
        $finish;
    end

endmodule
